// ==== filelist.f ====
+incdir+.
fragPipePkg.sv
valueDelay.sv
compareFunc.sv
colorBlender.sv
framebufferPipeline.sv
tileBuffer.sv
renderTop.sv
renderTop_properties.sv
renderTop_tb.sv

// ==== Makefile ====
# Verilator build and run of the render back end testbench

VERILATOR ?= verilator
TOP       := renderTop_tb
FILELIST  := filelist.f
MDIR      := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
SIM_BIN   := $(MDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All tests passed
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)

// ==== renderTop_tb.sv ====
/*
 * Render back end testbench
 * Seeded random fragments checked against a shadow buffer model
 * of the write stream, with a watchdog on the run time
 */

`timescale 1ns/10ps
`include "fragPipe_macros.svh"

module renderTop_tb import fragPipePkg::*; ();

    localparam int PERIOD       = 20;
    localparam int ENTRIES      = 1 << `FB_INDEX_WIDTH;
    localparam int NUM_TESTS    = 12;
    localparam int BATCH        = 40;
    // Worst case cycles of one test, a gap is at most one cycle
    localparam int BATCH_CYCLES = 2 * BATCH + 8;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * BATCH_CYCLES * PERIOD * 2;

    // Expected outputs of one fragment
    typedef struct packed {
        logic        valid;
        colorWrite_t colorWr;
        depthWrite_t depthWr;
    } expected_t;

    logic        aclk;
    logic        rstN;
    logic        fragValid;
    fragment_t   frag;
    fragConf_t   conf;
    logic        clear;
    pixel_t      clearColor;
    depth_t      clearDepth;
    logic        fragmentProcessed;
    colorWrite_t colorWr;
    depthWrite_t depthWr;

    // Shadow tile buffers
    pixel_t    shadowColor [ENTRIES];
    depth_t    shadowDepth [ENTRIES];
    // Index 0 is the newest fragment, 3 is the one at the outputs
    expected_t stage [4];
    int        errorCount;

    renderTop DUT (
        .aclk(aclk),
        .rstN(rstN),
        .fragValid(fragValid),
        .frag(frag),
        .conf(conf),
        .clear(clear),
        .clearColor(clearColor),
        .clearDepth(clearDepth),
        .fragmentProcessed(fragmentProcessed),
        .colorWr(colorWr),
        .depthWr(depthWr)
    );

    bind renderTop renderTopProperties props (
        .aclk(aclk), .rstN(rstN), .fragValid(fragValid),
        .fragmentProcessed(fragmentProcessed), .colorWr(colorWr), .depthWr(depthWr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic depth_t clampIncomingDepth(logic [31:0] z);
        if (z[31])
            return 16'h0000;
        if (z > 32'h0000_ffff)
            return 16'hffff;
        return z[15:0];
    endfunction

    function automatic bit compareResult(compareFunc_e func, int v, int r);
        case (func)
            cmpNever:        return 1'b0;
            cmpLess:         return v < r;
            cmpEqual:        return v == r;
            cmpLessEqual:    return v <= r;
            cmpGreater:      return v > r;
            cmpNotEqual:     return v != r;
            cmpGreaterEqual: return v >= r;
            default:         return 1'b1;
        endcase
    endfunction

    // Alpha weight is a plus its top bit
    function automatic int blendWeight(blendFactor_e f, int srcA, int dstA);
        int sw;
        int dw;
        sw = srcA + srcA / 128;
        dw = dstA + dstA / 128;
        case (f)
            blendOne:              return 256;
            blendSrcAlpha:         return sw;
            blendOneMinusSrcAlpha: return 256 - sw;
            blendDstAlpha:         return dw;
            blendOneMinusDstAlpha: return 256 - dw;
            default:               return 0;
        endcase
    endfunction

    function automatic int blendChannel(int s, int d, int ws, int wd);
        int v;
        v = (s * ws + d * wd) / 256;
        return (v > 255) ? 255 : v;
    endfunction

    function automatic expected_t predictWrite(fragment_t f, fragConf_t c);
        expected_t e;
        pixel_t    dst;
        depth_t    z;
        int        ws;
        int        wd;
        bit        pass;
        dst  = shadowColor[f.index];
        z    = clampIncomingDepth(f.depth);
        ws   = blendWeight(c.blendSrc, f.color.a, dst.a);
        wd   = blendWeight(c.blendDst, f.color.a, dst.a);
        pass = compareResult(c.alphaFunc, f.color.a, c.alphaRef) &&
               (!c.depthEnable || compareResult(c.depthFunc, z, shadowDepth[f.index]));
        e.valid           = 1'b1;
        e.colorWr.enable  = pass;
        e.colorWr.index   = f.index;
        e.colorWr.color.r = 8'(blendChannel(f.color.r, dst.r, ws, wd));
        e.colorWr.color.g = 8'(blendChannel(f.color.g, dst.g, ws, wd));
        e.colorWr.color.b = 8'(blendChannel(f.color.b, dst.b, ws, wd));
        e.colorWr.color.a = 8'(blendChannel(f.color.a, dst.a, ws, wd));
        e.depthWr.enable  = pass && c.depthEnable;
        e.depthWr.index   = f.index;
        e.depthWr.depth   = z;
        return e;
    endfunction

    // One rising edge of the model
    task automatic advanceModel();
        expected_t done;
        done = stage[3];
        // Fragment from four edges back commits here
        if (done.colorWr.enable)
            shadowColor[done.colorWr.index] = done.colorWr.color;
        if (done.depthWr.enable)
            shadowDepth[done.depthWr.index] = done.depthWr.depth;
        if (clear)
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                shadowColor[i] = clearColor;
                shadowDepth[i] = clearDepth;
            end
        end
        for (int k = 3; k > 0; k--)
            stage[k] = stage[k-1];
        stage[0] = fragValid ? predictWrite(frag, conf) : '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic failRun(string msg);
        errorCount++;
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
        failRun($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic checkOutputs();
        expected_t e;
        e = stage[3];
        assert (fragmentProcessed === e.valid)
            else reportMismatch("fragmentProcessed", 32'(fragmentProcessed), 32'(e.valid));
        assert (colorWr.enable === e.colorWr.enable)
            else reportMismatch("colorWr.enable", 32'(colorWr.enable), 32'(e.colorWr.enable));
        assert (depthWr.enable === e.depthWr.enable)
            else reportMismatch("depthWr.enable", 32'(depthWr.enable), 32'(e.depthWr.enable));
        if (e.colorWr.enable)
        begin
            assert (colorWr.index === e.colorWr.index)
                else reportMismatch("colorWr.index", 32'(colorWr.index), 32'(e.colorWr.index));
            assert (colorWr.color === e.colorWr.color)
                else reportMismatch("colorWr.color", colorWr.color, e.colorWr.color);
        end
        if (e.depthWr.enable)
        begin
            assert (depthWr.index === e.depthWr.index)
                else reportMismatch("depthWr.index", 32'(depthWr.index), 32'(e.depthWr.index));
            assert (depthWr.depth === e.depthWr.depth)
                else reportMismatch("depthWr.depth", 32'(depthWr.depth), 32'(e.depthWr.depth));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    // Mix of negative, above 1.0, equal to clear and in range depths
    function automatic logic [31:0] randomDepth(depth_t clearZ);
        case ($urandom_range(0, 4))
            0:       return 32'h8000_0000 | $urandom;
            1:       return {1'b0, 15'($urandom_range(1, 32767)), 16'($urandom)};
            2:       return {16'h0000, clearZ};
            default: return {16'h0000, 16'($urandom)};
        endcase
    endfunction

    task automatic randomConf(int t);
        if (t == 0)
        begin
            // Plain copy, no tests and no blending
            conf.alphaFunc   = cmpAlways;
            conf.alphaRef    = 8'h00;
            conf.depthFunc   = cmpAlways;
            conf.depthEnable = 1'b0;
            conf.blendSrc    = blendOne;
            conf.blendDst    = blendZero;
        end
        else
        begin
            conf.alphaFunc   = (t % 2 == 1) ? cmpAlways : compareFunc_e'($urandom_range(0, 7));
            conf.alphaRef    = 8'($urandom_range(0, 255));
            conf.depthFunc   = compareFunc_e'($urandom_range(0, 7));
            conf.depthEnable = 1'($urandom_range(0, 1));
            conf.blendSrc    = blendFactor_e'($urandom_range(0, 5));
            conf.blendDst    = blendFactor_e'($urandom_range(0, 5));
        end
    endtask

    task automatic runTest(int t);
        bit hazard;
        bit gap;
        // Every third test hammers four indices back to back
        hazard = (t % 3 == 2);
        @(posedge aclk);
        #2;
        randomConf(t);
        clear      = 1'b1;
        clearColor = $urandom;
        clearDepth = 16'($urandom);
        @(posedge aclk);
        #2;
        clear = 1'b0;
        for (int i = 0; i < BATCH; i++)
        begin
            fragValid  = 1'b1;
            frag.color = $urandom;
            if ($urandom_range(0, 3) == 0)
                frag.color.a = conf.alphaRef;
            frag.depth = randomDepth(clearDepth);
            frag.index = hazard ? fbIndex_t'($urandom_range(0, 3))
                                : fbIndex_t'($urandom_range(0, ENTRIES - 1));
            gap = hazard ? 1'b0 : 1'($urandom_range(0, 1));
            @(posedge aclk);
            #2;
            if (gap)
            begin
                fragValid = 1'b0;
                @(posedge aclk);
                #2;
            end
        end
        fragValid = 1'b0;
        // Drain the pipeline
        repeat (4) @(posedge aclk);
    endtask

    initial
    begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    initial
    begin
        for (int k = 0; k < 4; k++)
            stage[k] = '0;
        forever
        begin
            @(posedge aclk);
            if (rstN)
                advanceModel();
        end
    end

    initial
    begin
        forever
        begin
            @(negedge aclk);
            if (rstN)
                checkOutputs();
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        failRun("Watchdog expired before the tests completed");
    end

    initial
    begin
        void'($urandom(56261));
        errorCount = 0;
        rstN       = 1'b0;
        fragValid  = 1'b0;
        frag       = '0;
        conf       = '0;
        clear      = 1'b0;
        clearColor = '0;
        clearDepth = '0;
        repeat (16) @(posedge aclk);
        #2;
        rstN = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++)
            runTest(t);
        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== renderTop_properties.sv ====
/*
 * Write stream properties
 * Concurrent checks on the processed strobe and write enables
 */

`timescale 1ns/10ps

module renderTopProperties import fragPipePkg::*; (
    input logic        aclk,
    input logic        rstN,
    input logic        fragValid,
    input logic        fragmentProcessed,
    input colorWrite_t colorWr,
    input depthWrite_t depthWr
);

    // Writes only come with a processed fragment
    property writeNeedsProcessed;
        @(posedge aclk) disable iff (!rstN)
            (colorWr.enable || depthWr.enable) |-> fragmentProcessed;
    endproperty

    // Depth never written without its colour
    property depthNeedsColor;
        @(posedge aclk) disable iff (!rstN)
            depthWr.enable |-> colorWr.enable;
    endproperty

    // Fixed four cycle latency
    property processedLatency;
        @(posedge aclk) disable iff (!rstN)
            fragmentProcessed == $past(fragValid, 4);
    endproperty

    writeNeedsProcessedA: assert property (writeNeedsProcessed)
        else $error("write enable asserted while fragmentProcessed is low");
    depthNeedsColorA: assert property (depthNeedsColor)
        else $error("depth write enabled without a colour write");
    processedLatencyA: assert property (processedLatency)
        else $error("fragmentProcessed does not follow fragValid by four cycles");

endmodule

// ==== renderTop.sv ====
/*
 * Render back end top
 * Fragment pipeline joined to the colour and depth tile buffers
 */

`timescale 1ns/10ps
`include "fragPipe_macros.svh"

module renderTop import fragPipePkg::*; (
    input  logic        aclk,
    input  logic        rstN,
    input  logic        fragValid,
    input  fragment_t   frag,
    input  fragConf_t   conf,
    input  logic        clear,
    input  pixel_t      clearColor,
    input  depth_t      clearDepth,
    output logic        fragmentProcessed,
    output colorWrite_t colorWr,
    output depthWrite_t depthWr
);

    localparam int ENTRIES = 1 << `FB_INDEX_WIDTH;

    fbIndex_t readIndex;
    pixel_t   colorRead;
    depth_t   depthRead;

    framebufferPipeline pipe (
        .aclk(aclk),
        .rstN(rstN),
        .conf(conf),
        .fragValid(fragValid),
        .frag(frag),
        .fragmentProcessed(fragmentProcessed),
        .readIndex(readIndex),
        .colorIn(colorRead),
        .depthIn(depthRead),
        .colorWr(colorWr),
        .depthWr(depthWr)
    );

    // Colour tile
    tileBuffer #(.T(pixel_t), .DEPTH_ENTRIES(ENTRIES)) colorBuffer (
        .aclk(aclk), .readIndex(readIndex), .readData(colorRead),
        .wrEnable(colorWr.enable), .wrIndex(colorWr.index), .wrData(colorWr.color),
        .clear(clear), .clearValue(clearColor)
    );

    // Depth tile
    tileBuffer #(.T(depth_t), .DEPTH_ENTRIES(ENTRIES)) depthBuffer (
        .aclk(aclk), .readIndex(readIndex), .readData(depthRead),
        .wrEnable(depthWr.enable), .wrIndex(depthWr.index), .wrData(depthWr.depth),
        .clear(clear), .clearValue(clearDepth)
    );

endmodule

// ==== tileBuffer.sv ====
/*
 * Tile buffer
 * Register array with synchronous write-first read and a whole-array clear
 */

`timescale 1ns/10ps
`include "fragPipe_macros.svh"

module tileBuffer #(
    parameter type T = logic,
    parameter int  DEPTH_ENTRIES = 1 << `FB_INDEX_WIDTH
) (
    input  logic                             aclk,
    input  logic [$clog2(DEPTH_ENTRIES)-1:0] readIndex,
    output T                                 readData,
    input  logic                             wrEnable,
    input  logic [$clog2(DEPTH_ENTRIES)-1:0] wrIndex,
    input  T                                 wrData,
    input  logic                             clear,
    input  T                                 clearValue
);

    T mem [DEPTH_ENTRIES];

    // Clear wins over a write on the same edge
    always_ff @(posedge aclk)
    begin
        if (clear)
            for (int i = 0; i < DEPTH_ENTRIES; i++)
                mem[i] <= clearValue;
        else if (wrEnable)
            mem[wrIndex] <= wrData;
    end

    // A read on the committing edge already sees the new entry
    always_ff @(posedge aclk)
    begin
        if (clear)
            readData <= clearValue;
        else if (wrEnable && (wrIndex == readIndex))
            readData <= wrData;
        else
            readData <= mem[readIndex];
    end

endmodule

// ==== framebufferPipeline.sv ====
/*
 * Fragment pipeline
 * Depth clamp and buffer read, alpha and depth test with blend,
 * then registered write-back, four cycles from input to output
 */

`timescale 1ns/10ps
`include "fragPipe_macros.svh"

module framebufferPipeline import fragPipePkg::*; (
    input  logic        aclk,
    input  logic        rstN,
    input  fragConf_t   conf,
    input  logic        fragValid,
    input  fragment_t   frag,
    output logic        fragmentProcessed,
    output fbIndex_t    readIndex,
    input  pixel_t      colorIn,
    input  depth_t      depthIn,
    output colorWrite_t colorWr,
    output depthWrite_t depthWr
);

    // Negative goes to 0, above 1.0 saturates
    function automatic depth_t clampDepth(input logic [31:0] z);
        if (z[31])
            return '0;
        else if (|z[30:`DEPTH_WIDTH])
            return '1;
        else
            return z[`DEPTH_WIDTH-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // Step 0  buffer read, one cycle
    //////////////////////////////////////////////////////////////////////////
    logic     step0Valid;
    fbIndex_t step0Index;
    depth_t   step0Depth;
    pixel_t   step0Color;

    // Both buffers share the address
    assign readIndex = frag.index;

    valueDelay #(.T(logic), .DELAY(1))
        step0ValidDelay (.aclk(aclk), .in(fragValid), .out(step0Valid));
    valueDelay #(.T(fbIndex_t), .DELAY(1))
        step0IndexDelay (.aclk(aclk), .in(frag.index), .out(step0Index));
    valueDelay #(.T(depth_t), .DELAY(1))
        step0DepthDelay (.aclk(aclk), .in(clampDepth(frag.depth)), .out(step0Depth));
    valueDelay #(.T(pixel_t), .DELAY(1))
        step0ColorDelay (.aclk(aclk), .in(frag.color), .out(step0Color));

    //////////////////////////////////////////////////////////////////////////
    // Step 1  tests and blend, two cycles
    //////////////////////////////////////////////////////////////////////////
    logic     step1Valid;
    fbIndex_t step1Index;
    depth_t   step1Depth;
    pixel_t   step1Color;
    logic     alphaOk;
    logic     depthOk;
    logic     step1Pass;

    valueDelay #(.T(logic), .DELAY(2))
        step1ValidDelay (.aclk(aclk), .in(step0Valid), .out(step1Valid));
    valueDelay #(.T(fbIndex_t), .DELAY(2))
        step1IndexDelay (.aclk(aclk), .in(step0Index), .out(step1Index));
    valueDelay #(.T(depth_t), .DELAY(2))
        step1DepthDelay (.aclk(aclk), .in(step0Depth), .out(step1Depth));

    colorBlender blender (
        .aclk(aclk), .rstN(rstN),
        .srcFactor(conf.blendSrc), .dstFactor(conf.blendDst),
        .srcColor(step0Color), .dstColor(colorIn),
        .color(step1Color)
    );

    compareFunc #(.WIDTH(`SUB_PIXEL_WIDTH)) alphaTest (
        .aclk(aclk), .rstN(rstN), .func(conf.alphaFunc),
        .refVal(conf.alphaRef), .val(step0Color.a), .success(alphaOk)
    );

    // Clamped incoming depth against the stored depth
    compareFunc #(.WIDTH(`DEPTH_WIDTH)) depthTest (
        .aclk(aclk), .rstN(rstN), .func(conf.depthFunc),
        .refVal(depthIn), .val(step0Depth), .success(depthOk)
    );

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
            step1Pass <= 1'b0;
        else
            step1Pass <= alphaOk && (depthOk || !conf.depthEnable);
    end

    //////////////////////////////////////////////////////////////////////////
    // Step 2  write-back, one cycle
    //////////////////////////////////////////////////////////////////////////
    logic     colorWe;
    logic     depthWe;
    fbIndex_t wrIndex;
    pixel_t   wrColor;
    depth_t   wrDepth;

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            fragmentProcessed <= 1'b0;
            colorWe <= 1'b0;
            depthWe <= 1'b0;
        end
        else
        begin
            fragmentProcessed <= step1Valid;
            colorWe <= step1Valid && step1Pass;
            depthWe <= step1Valid && step1Pass && conf.depthEnable;
        end
    end

    // Payload only moves with a live fragment
    always_ff @(posedge aclk)
    begin
        if (step1Valid)
        begin
            wrIndex <= step1Index;
            wrColor <= step1Color;
            wrDepth <= step1Depth;
        end
    end

    assign colorWr = '{enable: colorWe, index: wrIndex, color: wrColor};
    assign depthWr = '{enable: depthWe, index: wrIndex, depth: wrDepth};

endmodule

// ==== colorBlender.sv ====
/*
 * Colour blender
 * Two stage per channel blend, src * srcFactor + dst * dstFactor,
 * shifted down by 8 and saturated to the channel range
 */

`timescale 1ns/10ps
`include "fragPipe_macros.svh"

module colorBlender import fragPipePkg::*; (
    input  logic         aclk,
    input  logic         rstN,
    input  blendFactor_e srcFactor,
    input  blendFactor_e dstFactor,
    input  pixel_t       srcColor,
    input  pixel_t       dstColor,
    output pixel_t       color
);

    localparam int CH = `SUB_PIXEL_WIDTH;

    // Alpha 255 must map to a full weight of 256
    function automatic logic [CH:0] alphaWeight(input logic [CH-1:0] alpha);
        return {1'b0, alpha} + (CH+1)'(alpha[CH-1]);
    endfunction

    function automatic logic [CH:0] factorWeight(
        input blendFactor_e    f,
        input logic [CH-1:0]   srcA,
        input logic [CH-1:0]   dstA
    );
        case (f)
            blendZero:             return '0;
            blendOne:              return (CH+1)'(1 << CH);
            blendSrcAlpha:         return alphaWeight(srcA);
            blendOneMinusSrcAlpha: return (CH+1)'(1 << CH) - alphaWeight(srcA);
            blendDstAlpha:         return alphaWeight(dstA);
            blendOneMinusDstAlpha: return (CH+1)'(1 << CH) - alphaWeight(dstA);
            default:               return '0;
        endcase
    endfunction

    // Channel view, index 0 is alpha and 3 is red
    logic [3:0][CH-1:0]  srcCh;
    logic [3:0][CH-1:0]  dstCh;
    logic [3:0][CH-1:0]  outCh;
    logic [CH:0]         srcW;
    logic [CH:0]         dstW;
    logic [2*CH:0]       srcProd [4];
    logic [2*CH:0]       dstProd [4];

    assign srcCh = srcColor;
    assign dstCh = dstColor;
    assign srcW  = factorWeight(srcFactor, srcColor.a, dstColor.a);
    assign dstW  = factorWeight(dstFactor, srcColor.a, dstColor.a);

    //////////////////////////////////////////////////////////////////////////
    // Stage 1  weighted products
    //////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 4; i++)
            begin
                srcProd[i] <= '0;
                dstProd[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                srcProd[i] <= srcCh[i] * srcW;
                dstProd[i] <= dstCh[i] * dstW;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage 2  sum, shift and saturate
    //////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN)
    begin
        logic [2*CH+1:0] sum;
        if (!rstN)
        begin
            outCh <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                sum = srcProd[i] + dstProd[i];
                // Anything at or above 256 after the shift clips to 255
                outCh[i] <= (|sum[2*CH+1:2*CH]) ? {CH{1'b1}} : sum[2*CH-1:CH];
            end
        end
    end

    assign color = outCh;

endmodule

// ==== compareFunc.sv ====
/*
 * Registered compare unit
 * Evaluates val against refVal with the selected compare function
 */

`timescale 1ns/10ps

module compareFunc import fragPipePkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic             aclk,
    input  logic             rstN,
    input  compareFunc_e     func,
    input  logic [WIDTH-1:0] refVal,
    input  logic [WIDTH-1:0] val,
    output logic             success
);

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            success <= 1'b0;
        end
        else
        begin
            case (func)
                cmpNever:        success <= 1'b0;
                cmpLess:         success <= val < refVal;
                cmpEqual:        success <= val == refVal;
                cmpLessEqual:    success <= val <= refVal;
                cmpGreater:      success <= val > refVal;
                cmpNotEqual:     success <= val != refVal;
                cmpGreaterEqual: success <= val >= refVal;
                default:         success <= 1'b1;
            endcase
        end
    end

endmodule

// ==== valueDelay.sv ====
/*
 * Value delay line
 * Shifts any payload type through DELAY registers without reset
 */

`timescale 1ns/10ps
`include "fragPipe_macros.svh"

module valueDelay #(
    parameter type T = logic,
    parameter int  DELAY = `VALUE_DELAY_DEFAULT
) (
    input  logic aclk,
    input  T     in,
    output T     out
);

    // Stage 0 holds the newest value
    T stages [DELAY];

    always_ff @(posedge aclk)
    begin
        stages[0] <= in;
        for (int i = 1; i < DELAY; i++)
        begin
            stages[i] <= stages[i-1];
        end
    end

    assign out = stages[DELAY-1];

endmodule

// ==== fragPipePkg.sv ====
/*
 * Fragment back end types
 * Pixel, fragment, configuration and buffer write structs together
 * with the compare function and blend factor encodings
 */

`include "fragPipe_macros.svh"

package fragPipePkg;

    // RGBA colour with alpha in the low byte
    typedef struct packed {
        logic [`SUB_PIXEL_WIDTH-1:0] r;
        logic [`SUB_PIXEL_WIDTH-1:0] g;
        logic [`SUB_PIXEL_WIDTH-1:0] b;
        logic [`SUB_PIXEL_WIDTH-1:0] a;
    } pixel_t;

    typedef logic [`FB_INDEX_WIDTH-1:0] fbIndex_t;
    typedef logic [`DEPTH_WIDTH-1:0] depth_t;

    // Depth is 32 bit fixed point, bit 31 set means negative
    typedef struct packed {
        pixel_t      color;
        logic [31:0] depth;
        fbIndex_t    index;
    } fragment_t;

    // Incoming value is compared against the reference
    typedef enum logic [2:0] {
        cmpNever,
        cmpLess,
        cmpEqual,
        cmpLessEqual,
        cmpGreater,
        cmpNotEqual,
        cmpGreaterEqual,
        cmpAlways
    } compareFunc_e;

    typedef enum logic [2:0] {
        blendZero,
        blendOne,
        blendSrcAlpha,
        blendOneMinusSrcAlpha,
        blendDstAlpha,
        blendOneMinusDstAlpha
    } blendFactor_e;

    // Static while fragments are in flight
    typedef struct packed {
        compareFunc_e                alphaFunc;
        logic [`SUB_PIXEL_WIDTH-1:0] alphaRef;
        compareFunc_e                depthFunc;
        logic                        depthEnable;
        blendFactor_e                blendSrc;
        blendFactor_e                blendDst;
    } fragConf_t;

    typedef struct packed {
        logic     enable;
        fbIndex_t index;
        pixel_t   color;
    } colorWrite_t;

    typedef struct packed {
        logic     enable;
        fbIndex_t index;
        depth_t   depth;
    } depthWrite_t;

endpackage

// ==== fragPipe_macros.svh ====
/*
 * Fragment back end widths
 * Tile index, stored depth and colour channel sizes, plus the
 * default length of the pipeline delay lines
 */

`ifndef FRAGPIPE_MACROS_SVH
`define FRAGPIPE_MACROS_SVH

// Tile index width, 64 entries per tile
`define FB_INDEX_WIDTH 6

// Stored depth, unsigned fraction of 1.0
`define DEPTH_WIDTH 16

// One colour channel
`define SUB_PIXEL_WIDTH 8

// Default stage count of a delay line
`define VALUE_DELAY_DEFAULT 1

`endif
